//--- common/vec_settings.svh
/* Build-wide sizes of the vector unit. VEC_REGS must be a power of two and
   VEC_VL_W must hold values up to 2*VEC_LANES so that out of range lengths can be seen */
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////
`define VEC_LANES  4   // SIMD lanes per vector
`define VEC_ELEM_W 32  // Bits per element

////////////////////////////////////////
// Architectural state
////////////////////////////////////////
`define VEC_REGS   8   // Vector registers in the file
`define VEC_VL_W   4   // Width of the vl field, 0 to 2*VEC_LANES

`endif

//--- common/vec_isa_pkg.sv
/* Architectural types seen by the CPU. Sizes come from vec_settings.svh */
`include "vec_settings.svh"

package vec_isa_pkg;

	////////////////////////////////////////
	// Operation codes
	////////////////////////////////////////
	typedef enum logic [2:0] {
		VSPLAT  = 3'd0, // vd lanes get rs1
		VADD    = 3'd1, // vs1 + vs2
		VSUB    = 3'd2, // vs1 - vs2
		VAND    = 3'd3, // Bitwise and
		VXOR    = 3'd4, // Bitwise xor
		VREDSUM = 3'd5  // Scalar sum of vs1, no write
	} vec_op_e;

	////////////////////////////////////////
	// Operand fields
	////////////////////////////////////////
	typedef logic [$clog2(`VEC_REGS)-1:0] vreg_t; // Register index
	typedef logic [`VEC_VL_W-1:0]         vlen_t; // Active length

	// One lane element and a full vector
	typedef logic [`VEC_ELEM_W-1:0]       velem_t;
	typedef velem_t [`VEC_LANES-1:0]      vvec_t; // Lane 0 in the low bits

endpackage

//--- common/vec_pipe_pkg.sv
/* Payloads that travel between the pipeline stages. Only meaningful
   together with vec_isa_pkg, which defines the field types */
package vec_pipe_pkg;

	import vec_isa_pkg::*;

	////////////////////////////////////////
	// Decode to issue
	////////////////////////////////////////
	typedef struct packed {
		vec_op_e op;      // Operation
		vreg_t   vd;      // Destination
		vreg_t   vs1;     // First source
		vreg_t   vs2;     // Second source
		vlen_t   vl;      // Active lanes
		velem_t  scalar;  // rs1 from the CPU
		logic    illegal; // Bad vl, execute as no-op
	} dec_instr_t;

	////////////////////////////////////////
	// Issue to execute
	////////////////////////////////////////
	typedef struct packed {
		vec_op_e op;      // Operation
		vreg_t   vd;      // Writeback target
		vlen_t   vl;      // Active lanes
		logic    illegal; // Suppress writeback, flag error
		vvec_t   a;       // Contents of vs1
		vvec_t   b;       // Contents of vs2
		velem_t  scalar;  // Splat value
		vvec_t   old;     // Old vd, for tail lanes
	} exec_instr_t;

endpackage

//--- hw/vec_pipe_buf.sv
/* One-entry buffer between two stages. Accepts only when empty, so a push
   and a pop never share a cycle and throughput is one entry every two cycles */
module vec_pipe_buf #(
	parameter type PAYLOAD_T = logic  // Entry type
) (
	input  logic     clk_i,
	input  logic     rstn_i,
	// Write side
	input  logic     in_valid_i,
	input  PAYLOAD_T in_data_i,
	output logic     in_ready_o,
	// Read side
	output logic     out_valid_o,
	output PAYLOAD_T out_data_o,
	input  logic     out_ready_i
);

	logic     full_q; // Entry occupied
	PAYLOAD_T data_q; // Stored entry

	assign in_ready_o  = ~full_q;
	assign out_valid_o = full_q;
	assign out_data_o  = data_q;  // Read side is not registered

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			full_q <= 1'b0;
		end else if (in_valid_i && in_ready_o) begin
			full_q <= 1'b1;  // Fill
		end else if (out_ready_i) begin
			full_q <= 1'b0;  // Drain, only reached when full or idle
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

endmodule

//--- hw/vec_ctrl.sv
/* CPU side four-phase req/ack port. Operands must stay stable while req_i is high;
   one instruction is in flight at a time and ack_o drops one edge after req_i falls */
module vec_ctrl import vec_isa_pkg::*; (
	input  logic    clk_i,
	input  logic    rstn_i,
	// CPU handshake
	input  logic    req_i,
	output logic    ack_o,
	input  vec_op_e op_i,
	input  vreg_t   vd_i,
	input  vreg_t   vs1_i,
	input  vreg_t   vs2_i,
	input  vlen_t   vl_i,
	input  velem_t  rs1_i,
	output velem_t  res_o,
	output logic    err_o,
	// Into decode
	output logic    push_valid_o,
	output vec_op_e push_op_o,
	output vreg_t   push_vd_o,
	output vreg_t   push_vs1_o,
	output vreg_t   push_vs2_o,
	output vlen_t   push_vl_o,
	output velem_t  push_scalar_o,
	// Completion from execute
	input  logic    done_i,
	input  velem_t  done_res_i,
	input  logic    done_err_i,
	output logic    idle_o
);

	typedef enum logic [1:0] { S_IDLE, S_PUSH, S_BUSY, S_ACK } state_e;
	state_e state_q;

	assign push_valid_o = (state_q == S_PUSH);  // Single cycle pulse
	assign idle_o       = (state_q == S_IDLE);

	////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q <= S_IDLE;
			ack_o   <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: if (req_i) state_q <= S_PUSH;  // ack_o is low here
				S_PUSH: state_q <= S_BUSY;            // Decode is free, no stall
				S_BUSY: begin
					if (done_i) begin
						ack_o   <= 1'b1;
						state_q <= S_ACK;
					end
				end
				S_ACK: begin
					if (!req_i) begin  // Phase four
						ack_o   <= 1'b0;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Instruction capture and result latch
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && req_i) begin
			push_op_o     <= op_i;
			push_vd_o     <= vd_i;
			push_vs1_o    <= vs1_i;
			push_vs2_o    <= vs2_i;
			push_vl_o     <= vl_i;
			push_scalar_o <= rs1_i;
		end
		if (state_q == S_BUSY && done_i) begin
			res_o <= done_res_i;  // Held through the ack phase
			err_o <= done_err_i;
		end
	end

endmodule

//--- hw/vec_decode.sv
/* Decode stage with one output register. The only place vl is checked;
   an illegal instruction still flows down the pipe and completes as a no-op */
`include "vec_settings.svh"

module vec_decode import vec_isa_pkg::*, vec_pipe_pkg::*; (
	input  logic       clk_i,
	input  logic       rstn_i,
	// From the controller
	input  logic       in_valid_i,
	input  vec_op_e    in_op_i,
	input  vreg_t      in_vd_i,
	input  vreg_t      in_vs1_i,
	input  vreg_t      in_vs2_i,
	input  vlen_t      in_vl_i,
	input  velem_t     in_scalar_i,
	output logic       in_ready_o,
	// To the first buffer
	output logic       out_valid_o,
	output dec_instr_t out_instr_o,
	input  logic       out_ready_i,
	output logic       idle_o
);

	dec_instr_t instr_d;  // Decoded, before the register

	always_comb begin
		instr_d.op      = in_op_i;
		instr_d.vd      = in_vd_i;
		instr_d.vs1     = in_vs1_i;
		instr_d.vs2     = in_vs2_i;
		instr_d.vl      = in_vl_i;
		instr_d.scalar  = in_scalar_i;
		// Zero length or more lanes than exist
		instr_d.illegal = (in_vl_i == '0) || (in_vl_i > vlen_t'(`VEC_LANES));
	end

	assign in_ready_o = ~out_valid_o | out_ready_i;  // Free or draining
	assign idle_o     = ~out_valid_o;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) out_instr_o <= instr_d;
	end

endmodule

//--- hw/vis/vec_issue.sv
/* Issue stage with the vector register file. Reads vs1, vs2 and the old vd
   on acceptance; writeback replaces a whole vector, tail merging is done in execute */
`include "vec_settings.svh"

module vec_issue import vec_isa_pkg::*, vec_pipe_pkg::*; (
	input  logic        clk_i,
	input  logic        rstn_i,
	// From the first buffer
	input  logic        in_valid_i,
	input  dec_instr_t  in_instr_i,
	output logic        in_ready_o,
	// To the second buffer
	output logic        out_valid_o,
	output exec_instr_t out_instr_o,
	input  logic        out_ready_i,
	// Writeback from execute
	input  logic        wb_en_i,
	input  vreg_t       wb_reg_i,
	input  vvec_t       wb_data_i,
	output logic        idle_o
);

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////
	vvec_t rf_q [`VEC_REGS];  // Architectural vector state

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			for (int i = 0; i < `VEC_REGS; i++) begin
				rf_q[i] <= '0;  // Known start for the CPU
			end
		end else if (wb_en_i) begin
			rf_q[wb_reg_i] <= wb_data_i;
		end
	end

	////////////////////////////////////////
	// Operand read
	////////////////////////////////////////
	logic        accept;  // Entry taken this cycle
	exec_instr_t exec_d;  // Payload with operands

	assign accept     = in_valid_i & in_ready_o;
	assign in_ready_o = ~out_valid_o | out_ready_i;
	assign idle_o     = ~out_valid_o;

	always_comb begin
		exec_d.op      = in_instr_i.op;
		exec_d.vd      = in_instr_i.vd;
		exec_d.vl      = in_instr_i.vl;
		exec_d.illegal = in_instr_i.illegal;
		exec_d.scalar  = in_instr_i.scalar;
		// No forwarding needed, only one instruction in flight
		exec_d.a       = rf_q[in_instr_i.vs1];
		exec_d.b       = rf_q[in_instr_i.vs2];
		exec_d.old     = rf_q[in_instr_i.vd];
	end

	// Output register
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			out_instr_o <= exec_d;
		end
	end

endmodule

//--- hw/vex/vec_exec.sv
/* Two-stage integer SIMD execute. Never stalls; done_o pulses two cycles after
   acceptance with the writeback in the same cycle. Sums wrap at VEC_ELEM_W bits */
`include "vec_settings.svh"

module vec_exec import vec_isa_pkg::*, vec_pipe_pkg::*; (
	input  logic        clk_i,
	input  logic        rstn_i,
	// From the second buffer
	input  logic        in_valid_i,
	input  exec_instr_t in_instr_i,
	output logic        in_ready_o,
	// Writeback to issue
	output logic        wb_en_o,
	output vreg_t       wb_reg_o,
	output vvec_t       wb_data_o,
	// Completion to the controller
	output logic        done_o,
	output velem_t      done_res_o,
	output logic        done_err_o,
	output logic        idle_o
);

	logic                  s1_valid_q;
	vec_op_e               s1_op_q;
	vreg_t                 s1_vd_q;
	logic                  s1_illegal_q;
	logic [`VEC_LANES-1:0] s1_mask_q;  // Active lanes
	vvec_t                 s1_vec_q;   // Merged result vector
	vvec_t                 s1_a_q;     // vs1, for the reduction
	logic [`VEC_LANES-1:0] mask_d;
	vvec_t                 vec_d;
	velem_t                sum_d;

	assign in_ready_o = 1'b1;
	assign idle_o     = ~s1_valid_q & ~done_o;

	////////////////////////////////////////
	// Stage one, lane ops and tail merge
	////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < `VEC_LANES; i++) begin
			mask_d[i] = ~in_instr_i.illegal && (vlen_t'(i) < in_instr_i.vl);
			vec_d[i]  = in_instr_i.old[i];  // Tail lanes keep old vd
			if (mask_d[i]) begin
				case (in_instr_i.op)
					VSPLAT:  vec_d[i] = in_instr_i.scalar;
					VADD:    vec_d[i] = in_instr_i.a[i] + in_instr_i.b[i];
					VSUB:    vec_d[i] = in_instr_i.a[i] - in_instr_i.b[i];
					VAND:    vec_d[i] = in_instr_i.a[i] & in_instr_i.b[i];
					VXOR:    vec_d[i] = in_instr_i.a[i] ^ in_instr_i.b[i];
					default: vec_d[i] = in_instr_i.old[i];  // VREDSUM
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Stage two, reduction and result
	////////////////////////////////////////
	always_comb begin
		sum_d = '0;
		for (int i = 0; i < `VEC_LANES; i++) begin
			if (s1_mask_q[i]) sum_d = sum_d + s1_a_q[i];
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			s1_valid_q <= 1'b0;
			done_o     <= 1'b0;
			wb_en_o    <= 1'b0;
		end else begin
			s1_valid_q <= in_valid_i;
			done_o     <= s1_valid_q;
			wb_en_o    <= s1_valid_q && !s1_illegal_q && (s1_op_q != VREDSUM);
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i) begin
			s1_op_q      <= in_instr_i.op;
			s1_vd_q      <= in_instr_i.vd;
			s1_illegal_q <= in_instr_i.illegal;
			s1_mask_q    <= mask_d;
			s1_vec_q     <= vec_d;
			s1_a_q       <= in_instr_i.a;
		end
		if (s1_valid_q) begin
			wb_reg_o   <= s1_vd_q;
			wb_data_o  <= s1_vec_q;
			done_res_o <= (s1_op_q == VREDSUM) ? sum_d : s1_vec_q[0];  // Element 0 of new vd
			done_err_o <= s1_illegal_q;
		end
	end

endmodule

//--- hw/vec_unit_top.sv
/* Vector co-processor top. One instruction at a time over four-phase req/ack;
   latency is not fixed, the CPU waits for ack_o */
module vec_unit_top import vec_isa_pkg::*, vec_pipe_pkg::*; (
	input  logic    clk_i,
	input  logic    rstn_i,
	input  logic    req_i,
	output logic    ack_o,
	input  vec_op_e op_i,
	input  vreg_t   vd_i,
	input  vreg_t   vs1_i,
	input  vreg_t   vs2_i,
	input  vlen_t   vl_i,
	input  velem_t  rs1_i,
	output velem_t  res_o,
	output logic    err_o,
	output logic    idle_o
);

	logic        push_valid, done, done_err, wb_en;
	vec_op_e     push_op;
	vreg_t       push_vd, push_vs1, push_vs2, wb_reg;
	vlen_t       push_vl;
	velem_t      push_scalar, done_res;
	vvec_t       wb_data;
	logic        ctrl_idle, dec_idle, iss_idle, exe_idle;
	logic        dec_valid, dec_ready, b1_valid, iss_ready;
	logic        iss_valid, b2_ready, b2_valid, exe_ready;
	dec_instr_t  dec_instr, b1_instr;
	exec_instr_t iss_instr, b2_instr;

	assign idle_o = ctrl_idle & dec_idle & iss_idle & exe_idle;

	////////////////////////////////////////
	// Controller and decode
	////////////////////////////////////////
	vec_ctrl vec_ctrl_i (
		.clk_i, .rstn_i, .req_i, .ack_o, .op_i, .vd_i, .vs1_i, .vs2_i, .vl_i, .rs1_i,
		.res_o, .err_o,
		.push_valid_o (push_valid), .push_op_o (push_op), .push_vd_o (push_vd),
		.push_vs1_o (push_vs1), .push_vs2_o (push_vs2), .push_vl_o (push_vl),
		.push_scalar_o (push_scalar),
		.done_i (done), .done_res_i (done_res), .done_err_i (done_err), .idle_o (ctrl_idle)
	);

	vec_decode vec_decode_i (
		.clk_i, .rstn_i,
		.in_valid_i (push_valid), .in_op_i (push_op), .in_vd_i (push_vd),
		.in_vs1_i (push_vs1), .in_vs2_i (push_vs2), .in_vl_i (push_vl),
		.in_scalar_i (push_scalar),
		.in_ready_o (),  // Always free when the controller pushes
		.out_valid_o (dec_valid), .out_instr_o (dec_instr), .out_ready_i (dec_ready),
		.idle_o (dec_idle)
	);

	////////////////////////////////////////
	// Issue and execute
	////////////////////////////////////////
	vec_pipe_buf #(.PAYLOAD_T(dec_instr_t)) dec_iss_buf_i (
		.clk_i, .rstn_i,
		.in_valid_i (dec_valid), .in_data_i (dec_instr), .in_ready_o (dec_ready),
		.out_valid_o (b1_valid), .out_data_o (b1_instr), .out_ready_i (iss_ready)
	);

	vec_issue vec_issue_i (
		.clk_i, .rstn_i,
		.in_valid_i (b1_valid), .in_instr_i (b1_instr), .in_ready_o (iss_ready),
		.out_valid_o (iss_valid), .out_instr_o (iss_instr), .out_ready_i (b2_ready),
		.wb_en_i (wb_en), .wb_reg_i (wb_reg), .wb_data_i (wb_data), .idle_o (iss_idle)
	);

	vec_pipe_buf #(.PAYLOAD_T(exec_instr_t)) iss_exe_buf_i (
		.clk_i, .rstn_i,
		.in_valid_i (iss_valid), .in_data_i (iss_instr), .in_ready_o (b2_ready),
		.out_valid_o (b2_valid), .out_data_o (b2_instr), .out_ready_i (exe_ready)
	);

	vec_exec vec_exec_i (
		.clk_i, .rstn_i,
		.in_valid_i (b2_valid), .in_instr_i (b2_instr), .in_ready_o (exe_ready),
		.wb_en_o (wb_en), .wb_reg_o (wb_reg), .wb_data_o (wb_data),
		.done_o (done), .done_res_o (done_res), .done_err_o (done_err), .idle_o (exe_idle)
	);

endmodule

//--- tests/tb_clkgen.sv
/* Free running 100 ns clock and an active low reset held for five cycles.
   Reset is released 10 ns after a rising edge, like all other stimulus */
module tb_clkgen (
	output logic clk_o,
	output logic rstn_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_NS    = 50;  // Half of the 100 ns period
	localparam int RST_CYCLES = 5;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	initial begin
		rstn_o = 1'b0;                      // Asserted from time zero
		repeat (RST_CYCLES) @(posedge clk_o);
		#10 rstn_o = 1'b1;
	end

endmodule

//--- tests/tb_checker.sv
/* Watches the vector unit ports, keeps a shadow register file and compares
   each completion with a reference model. Assumes one instruction in flight */
`include "vec_settings.svh"

module tb_checker import vec_isa_pkg::*; (
	input  logic    clk_i,
	input  logic    rstn_i,
	input  logic    req_i,
	input  logic    ack_i,
	input  vec_op_e op_i,
	input  vreg_t   vd_i,
	input  vreg_t   vs1_i,
	input  vreg_t   vs2_i,
	input  vlen_t   vl_i,
	input  velem_t  rs1_i,
	input  velem_t  res_i,
	input  logic    err_i,
	input  logic    idle_i,
	input  int      test_id_i,  // Zero when no test runs
	output int      checks_o,
	output int      errors_o
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		vvec_t  vec;  // New vd contents
		velem_t res;  // Scalar returned on res_o
		logic   err;  // Bad vl
	} ref_t;

	vvec_t   shadow [`VEC_REGS];  // Expected register file
	vec_op_e cap_op;              // Instruction seen at the req_i rise
	vreg_t   cap_vd, cap_vs1, cap_vs2;
	vlen_t   cap_vl;
	velem_t  cap_rs1;
	ref_t    held;                // Expected result while ack_o is high
	logic    req_q, ack_q;        // Samples from the previous falling edge
	logic    rst_checked;
	int      cur_test, test_checks, test_errors, checks, errors;

	assign checks_o = checks;
	assign errors_o = errors;

	initial begin
		for (int i = 0; i < `VEC_REGS; i++) begin
			shadow[i] = '0;  // Register file comes out of reset cleared
		end
		req_q       = 1'b0;
		ack_q       = 1'b0;
		rst_checked = 1'b0;
		cur_test    = 0;
		test_checks = 0;
		test_errors = 0;
		checks      = 0;
		errors      = 0;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic ref_t ref_model(vec_op_e op, vvec_t a, vvec_t b, vvec_t old,
			velem_t scalar, vlen_t vl);
		ref_t r;
		r.vec = old;                        // Tail lanes keep their value
		r.res = '0;
		r.err = (vl == '0) || (int'(vl) > `VEC_LANES);
		if (!r.err) begin
			for (int i = 0; i < `VEC_LANES; i++) begin
				if (i < int'(vl)) begin
					case (op)
						VSPLAT:  r.vec[i] = scalar;
						VADD:    r.vec[i] = a[i] + b[i];
						VSUB:    r.vec[i] = a[i] - b[i];
						VAND:    r.vec[i] = a[i] & b[i];
						VXOR:    r.vec[i] = a[i] ^ b[i];
						default: r.res = r.res + a[i];  // Wraps at element width
					endcase
				end
			end
			if (op != VREDSUM) r.res = r.vec[0];
		end
		return r;
	endfunction

	function automatic string test_name(int id);
		case (id)
			1:       return "reset state";
			2:       return "splat and reduce";
			3:       return "random lane ops";
			4:       return "illegal vl";
			5:       return "held request";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare_value(input string what, input logic [`VEC_ELEM_W-1:0] got,
			input logic [`VEC_ELEM_W-1:0] want);
		checks++;
		test_checks++;
		if (got !== want) begin
			errors++;
			test_errors++;
			$display("ERR at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_protocol(input logic ok, input string msg);
		checks++;
		test_checks++;
		if (!ok) begin
			errors++;
			test_errors++;
			$display("Handshake error at time %0t: %s", $time, msg);
		end
	endtask

	////////////////////////////////////////
	// Monitor sampled on the falling edge
	////////////////////////////////////////
	always @(negedge clk_i) begin
		ref_t want;
		if (rstn_i) begin
			if (test_id_i != cur_test) begin
				if (cur_test != 0) begin
					$display("Test %0d (%s) finished: %0d checks, %0d errors",
						cur_test, test_name(cur_test), test_checks, test_errors);
				end
				cur_test    = test_id_i;
				test_checks = 0;
				test_errors = 0;
			end
			if (!rst_checked) begin  // First cycle out of reset
				check_protocol(idle_i === 1'b1, "idle_o is not high after reset");
				check_protocol(ack_i === 1'b0, "ack_o is not low after reset");
				rst_checked = 1'b1;
			end
			if (req_i && !req_q) begin  // Operands are stable from here
				cap_op  = op_i;
				cap_vd  = vd_i;
				cap_vs1 = vs1_i;
				cap_vs2 = vs2_i;
				cap_vl  = vl_i;
				cap_rs1 = rs1_i;
			end
			if (ack_i && !ack_q) begin
				want = ref_model(cap_op, shadow[cap_vs1], shadow[cap_vs2], shadow[cap_vd],
					cap_rs1, cap_vl);
				compare_value("err_o", `VEC_ELEM_W'(err_i), `VEC_ELEM_W'(want.err));
				if (!want.err) compare_value("res_o", res_i, want.res);
				if (!want.err && cap_op != VREDSUM) shadow[cap_vd] = want.vec;
				held = want;
			end else if (ack_q && req_q) begin  // CPU still holding req_i
				check_protocol(ack_i === 1'b1, "ack_o fell while req_i was still high");
				if (ack_i && !held.err) compare_value("held res_o", res_i, held.res);
			end else if (ack_q) begin
				check_protocol(ack_i === 1'b0, "ack_o did not fall one cycle after req_i");
			end
			req_q = req_i;
			ack_q = ack_i;
		end
	end

endmodule

//--- tests/tb_top.sv
/* Testbench top. Drives the four-phase port 10 ns after the rising edge;
   random fields come from an LFSR and assume VEC_ELEM_W of at most 32 */
`include "vec_settings.svh"

module tb_top import vec_isa_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_RANDOM    = 200;  // Random lane ops in test 3
	localparam int ACK_LIMIT   = 40;   // Cycles before a handshake counts as stuck
	localparam int DRIVE_NS    = 10;
	localparam int VREG_BITS   = $clog2(`VEC_REGS);
	localparam int LANE_BITS   = $clog2(`VEC_LANES);
	localparam int N_INSTR     = 1 + 2 * `VEC_LANES + `VEC_REGS + 2 * N_RANDOM + 7 + 4;
	localparam int WATCHDOG_NS = N_INSTR * 40 * 100;

	logic        clk, rstn, req, ack, err, idle;
	vec_op_e     op;
	vreg_t       vd, vs1, vs2;
	vlen_t       vl;
	velem_t      rs1, res;
	int          test_id, checks, errors, stalls;
	logic [31:0] lfsr_q;  // Random state

	tb_clkgen clkgen_i (.clk_o (clk), .rstn_o (rstn));

	vec_unit_top vec_unit_top_i (
		.clk_i (clk), .rstn_i (rstn), .req_i (req), .ack_o (ack), .op_i (op),
		.vd_i (vd), .vs1_i (vs1), .vs2_i (vs2), .vl_i (vl), .rs1_i (rs1),
		.res_o (res), .err_o (err), .idle_o (idle)
	);

	tb_checker checker_i (
		.clk_i (clk), .rstn_i (rstn), .req_i (req), .ack_i (ack), .op_i (op),
		.vd_i (vd), .vs1_i (vs1), .vs2_i (vs2), .vl_i (vl), .rs1_i (rs1),
		.res_i (res), .err_i (err), .idle_i (idle), .test_id_i (test_id),
		.checks_o (checks), .errors_o (errors)
	);

	////////////////////////////////////////
	// Random source
	////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);  // One step per bit
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// One full four-phase transfer, req_i held for hold_a cycles past ack_o
	task automatic run_instr(input vec_op_e op_a, input int vd_a, input int vs1_a,
			input int vs2_a, input int vl_a, input velem_t rs1_a, input int hold_a);
		int n;
		@(posedge clk);
		#(DRIVE_NS);
		op  = op_a;
		vd  = vreg_t'(vd_a);
		vs1 = vreg_t'(vs1_a);
		vs2 = vreg_t'(vs2_a);
		vl  = vlen_t'(vl_a);
		rs1 = rs1_a;
		req = 1'b1;
		n   = 0;
		while (ack !== 1'b1 && n < ACK_LIMIT) begin
			@(posedge clk);
			#(DRIVE_NS);
			n++;
		end
		if (ack !== 1'b1) begin
			$display("DUT gave no ack_o within %0d cycles, time %0t", ACK_LIMIT, $time);
			stalls++;
		end
		repeat (hold_a) begin
			@(posedge clk);
			#(DRIVE_NS);
		end
		req = 1'b0;
		n   = 0;
		while (ack !== 1'b0 && n < ACK_LIMIT) begin
			@(posedge clk);
			#(DRIVE_NS);
			n++;
		end
		if (ack !== 1'b0) begin
			$display("ack_o stayed high after req_i fell, time %0t", $time);
			stalls++;
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		vec_op_e rop;
		int      rvd, rvs1, rvs2, rvl;
		req     = 1'b0;
		op      = VSPLAT;
		vd      = '0;
		vs1     = '0;
		vs2     = '0;
		vl      = '0;
		rs1     = '0;
		test_id = 0;
		stalls  = 0;
		lfsr_q  = 32'hdcbad142;
		@(posedge rstn);

		test_id = 1;  // Cleared register sums to zero
		run_instr(VREDSUM, 0, 3, 0, `VEC_LANES, '0, 0);

		test_id = 2;
		for (int v = 1; v <= `VEC_LANES; v++) begin
			run_instr(VSPLAT, 1, 0, 0, v, velem_t'(take_bits(32)), 0);
			run_instr(VREDSUM, 0, 1, 0, v, '0, 0);  // Expect v times rs1
		end

		test_id = 3;
		for (int r = 0; r < `VEC_REGS; r++) begin
			run_instr(VSPLAT, r, 0, 0, `VEC_LANES, velem_t'(take_bits(32)), 0);
		end
		for (int k = 0; k < N_RANDOM; k++) begin
			rop  = vec_op_e'(3'(take_bits(2) + 32'd1));  // VADD to VXOR
			rvd  = int'(take_bits(VREG_BITS));
			rvs1 = int'(take_bits(VREG_BITS));
			rvs2 = int'(take_bits(VREG_BITS));
			rvl  = int'(take_bits(LANE_BITS)) + 1;
			run_instr(rop, rvd, rvs1, rvs2, rvl, '0, 0);
			run_instr(VREDSUM, 0, rvd, 0, `VEC_LANES, '0, 0);  // Whole register, tails too
		end

		test_id = 4;
		run_instr(VSPLAT, 2, 0, 0, `VEC_LANES, velem_t'(take_bits(32)), 0);
		run_instr(VADD, 2, 3, 4, 0, '0, 0);
		run_instr(VREDSUM, 0, 2, 0, `VEC_LANES, '0, 0);
		run_instr(VSPLAT, 2, 0, 0, `VEC_LANES + 1, velem_t'(take_bits(32)), 0);
		run_instr(VREDSUM, 0, 2, 0, `VEC_LANES, '0, 0);
		run_instr(VXOR, 2, 5, 6, 2 * `VEC_LANES, '0, 0);
		run_instr(VREDSUM, 0, 2, 0, `VEC_LANES, '0, 0);

		test_id = 5;  // CPU is slow to drop req_i
		run_instr(VSPLAT, 5, 0, 0, `VEC_LANES, velem_t'(take_bits(32)),
			int'(take_bits(3)) + 1);
		run_instr(VREDSUM, 0, 5, 0, `VEC_LANES, '0, int'(take_bits(3)) + 1);
		run_instr(VADD, 6, 5, 5, `VEC_LANES, '0, int'(take_bits(3)) + 1);
		run_instr(VREDSUM, 0, 6, 0, `VEC_LANES, '0, int'(take_bits(3)) + 1);

		test_id = 0;
		repeat (2) @(posedge clk);  // Lets the checker close the last test
		$display("Totals: %0d checks, %0d errors, %0d stuck handshakes", checks, errors, stalls);
		if (errors == 0 && stalls == 0 && checks > 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog sized from the instruction count
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/vec_isa_pkg.sv
common/vec_pipe_pkg.sv
hw/vec_pipe_buf.sv
hw/vec_ctrl.sv
hw/vec_decode.sv
hw/vis/vec_issue.sv
hw/vex/vec_exec.sv
hw/vec_unit_top.sv
tests/tb_clkgen.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the vector unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_top -f vlog.f -o tb_top_sim \
	&& ./obj_dir/tb_top_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
